//--- hw/alu_arith_unit.sv
`timescale 1ns/100ps

module alu_arith_unit import alu_op_pkg::*, alu_data_pkg::*; #(
  parameter int unsigned XLEN = XLEN_DEFAULT
) (
  input  alu_op_e         operator_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  output logic [XLEN-1:0] add_result_o,
  output logic [XLEN-1:0] shadd_result_o,
  output logic [XLEN-1:0] minmax_result_o,
  output logic            cmp_result_o
);

  ////////////////////////////////////////
  // Adder
  ////////////////////////////////////////

  logic            sub_op;
  logic [XLEN-1:0] adder_op_b;

  assign sub_op = (operator_i == ALU_SUB);

  // Two's complement negate as inverted B plus carry-in
  assign adder_op_b   = sub_op ? ~operand_b_i : operand_b_i;
  assign add_result_o = operand_a_i + adder_op_b + {{(XLEN-1){1'b0}}, sub_op};

  ////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////

  logic          cmp_signed;
  logic          is_equal;
  // Shared by signed and unsigned forms
  logic          is_greater;
  logic [XLEN:0] cmp_a_ext;
  logic [XLEN:0] cmp_b_ext;

  assign cmp_signed = op_is_signed(operator_i);
  assign is_equal   = (operand_a_i == operand_b_i);

  // Sign bit copied up only for signed ops
  assign cmp_a_ext  = {operand_a_i[XLEN-1] & cmp_signed, operand_a_i};
  assign cmp_b_ext  = {operand_b_i[XLEN-1] & cmp_signed, operand_b_i};
  assign is_greater = $signed(cmp_a_ext) > $signed(cmp_b_ext);

  always_comb begin
    case (operator_i)
      ALU_EQ:             cmp_result_o = is_equal;
      ALU_NE:             cmp_result_o = ~is_equal;
      ALU_GES, ALU_GEU:   cmp_result_o = is_greater | is_equal;
      ALU_LTS, ALU_LTU,
      ALU_SLTS, ALU_SLTU: cmp_result_o = ~(is_greater | is_equal);
      default:            cmp_result_o = 1'b0;
    endcase
  end

  // Min and max
  // Equal operands give B
  always_comb begin
    case (operator_i)
      ALU_MAX, ALU_MAXU: minmax_result_o = is_greater ? operand_a_i : operand_b_i;
      default:           minmax_result_o = (is_greater || is_equal) ? operand_b_i : operand_a_i;
    endcase
  end

  ////////////////////////////////////////
  // Shift-add
  ////////////////////////////////////////

  logic [XLEN-1:0] shadd_op_a;

  always_comb begin
    case (operator_i)
      ALU_SH1ADD: shadd_op_a = {operand_a_i[XLEN-2:0], 1'b0};
      ALU_SH2ADD: shadd_op_a = {operand_a_i[XLEN-3:0], 2'b0};
      // SH3ADD
      default:    shadd_op_a = {operand_a_i[XLEN-4:0], 3'b0};
    endcase
  end

  assign shadd_result_o = shadd_op_a + operand_b_i;

endmodule

//--- hw/alu_data_pkg.sv
package alu_data_pkg;

  // Datapath width used unless the top level is told otherwise
  localparam int unsigned XLEN_DEFAULT = 32;

  // Extra shift amount bit
  // Keeps the negated amount for right shifts in range
  localparam int unsigned SHAMT_EXTRA = 1;

  // Shift amount width over the double-width funnel
  function automatic int unsigned shamt_width(int unsigned xlen);
    return $clog2(xlen) + SHAMT_EXTRA;
  endfunction

endpackage

//--- hw/alu_op_pkg.sv
package alu_op_pkg;

  localparam int unsigned ALU_OP_W = 6;

  // Codes left out of this list decode to a zero result
  typedef enum logic [ALU_OP_W-1:0] {
    ALU_LTS    = 6'b000000,
    ALU_LTU    = 6'b000001,
    ALU_SLTS   = 6'b000010,
    ALU_SLTU   = 6'b000011,
    ALU_GES    = 6'b001010,
    ALU_GEU    = 6'b001011,
    ALU_EQ     = 6'b001100,
    ALU_NE     = 6'b001101,
    ALU_MIN    = 6'b010000,
    ALU_MAX    = 6'b010001,
    ALU_MINU   = 6'b010010,
    ALU_MAXU   = 6'b010011,
    ALU_AND    = 6'b010101,
    ALU_ADD    = 6'b011000,
    ALU_SUB    = 6'b011001,
    ALU_SH1ADD = 6'b011010,
    ALU_SH2ADD = 6'b011011,
    ALU_SH3ADD = 6'b011100,
    ALU_SRA    = 6'b100100,
    ALU_SRL    = 6'b100101,
    ALU_ROR    = 6'b100110,
    ALU_SLL    = 6'b100111,
    ALU_ROL    = 6'b101000,
    ALU_BSET   = 6'b101001,
    ALU_BCLR   = 6'b101010,
    ALU_BINV   = 6'b101011,
    ALU_BEXT   = 6'b101100,
    ALU_ANDN   = 6'b101101,
    ALU_OR     = 6'b101110,
    ALU_XOR    = 6'b101111,
    ALU_ORN    = 6'b110000,
    ALU_XNOR   = 6'b110001
  } alu_op_e;

  // Signed ordering for compares and min/max
  function automatic logic op_is_signed(alu_op_e op);
    return (op == ALU_GES) || (op == ALU_LTS) || (op == ALU_SLTS) ||
           (op == ALU_MIN) || (op == ALU_MAX);
  endfunction

  // Ops that run the funnel shifter to the right
  function automatic logic op_is_rshift(alu_op_e op);
    return (op == ALU_SRL) || (op == ALU_SRA) || (op == ALU_ROR) || (op == ALU_BEXT);
  endfunction

  // Single-bit ops that need a one-hot mask
  function automatic logic op_is_onehot(alu_op_e op);
    return (op == ALU_BSET) || (op == ALU_BCLR) || (op == ALU_BINV);
  endfunction

endpackage

//--- hw/alu_result_mux.sv
`timescale 1ns/100ps

module alu_result_mux import alu_op_pkg::*, alu_data_pkg::*; #(
  parameter int unsigned XLEN = XLEN_DEFAULT
) (
  input  alu_op_e         operator_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  input  logic [XLEN-1:0] shift_result_i,
  input  logic [XLEN-1:0] bit_result_i,
  input  logic [XLEN-1:0] add_result_i,
  input  logic [XLEN-1:0] shadd_result_i,
  input  logic [XLEN-1:0] minmax_result_i,
  input  logic            cmp_result_i,
  output logic [XLEN-1:0] result_o,
  output logic            comparison_result_o
);

  // Branch compares only need the bit
  assign comparison_result_o = cmp_result_i;

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////

  always_comb begin
    case (operator_i)
      // Plain bitwise logic
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_ANDN: result_o = operand_a_i & ~operand_b_i;
      ALU_ORN:  result_o = operand_a_i | ~operand_b_i;
      ALU_XNOR: result_o = operand_a_i ^ ~operand_b_i;

      // Adder
      ALU_ADD, ALU_SUB: result_o = add_result_i;
      ALU_SH1ADD, ALU_SH2ADD,
      ALU_SH3ADD:       result_o = shadd_result_i;

      // Shifter
      ALU_SLL, ALU_SRL, ALU_SRA,
      ALU_ROL, ALU_ROR: result_o = shift_result_i;
      ALU_BSET, ALU_BCLR,
      ALU_BINV, ALU_BEXT: result_o = bit_result_i;

      // Set-less-than widens the compare bit
      ALU_SLTS, ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, cmp_result_i};

      ALU_MIN, ALU_MINU,
      ALU_MAX, ALU_MAXU: result_o = minmax_result_i;

      // Branch compares and unknown codes
      default: result_o = '0;
    endcase
  end

endmodule

//--- hw/alu_shift_unit.sv
`timescale 1ns/100ps

module alu_shift_unit import alu_op_pkg::*, alu_data_pkg::*; #(
  parameter int unsigned XLEN = XLEN_DEFAULT
) (
  input  alu_op_e         operator_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  output logic [XLEN-1:0] shift_result_o,
  output logic [XLEN-1:0] bit_result_o
);

  localparam int unsigned SHAMT_W = shamt_width(XLEN);
  localparam int unsigned IDX_W   = SHAMT_W - SHAMT_EXTRA;

  ////////////////////////////////////////
  // Operator decode
  ////////////////////////////////////////

  logic               rotate;
  logic               rshift;
  logic               arithmetic;
  // A becomes 1 and the fill 0, giving a one-hot mask
  logic               tieoff;

  logic [XLEN-1:0]    base_word;
  logic [XLEN-1:0]    fill_word;
  logic [SHAMT_W-1:0] raw_amt;
  logic [SHAMT_W-1:0] shift_amt;

  assign rotate     = (operator_i == ALU_ROL) || (operator_i == ALU_ROR);
  assign rshift     = op_is_rshift(operator_i);
  assign arithmetic = (operator_i == ALU_SRA);
  assign tieoff     = op_is_onehot(operator_i);

  // Amount is taken modulo XLEN
  assign raw_amt = {{SHAMT_EXTRA{1'b0}}, operand_b_i[IDX_W-1:0]};
  // Right shift is a left rotate by the negated amount
  assign shift_amt = rshift ? -raw_amt : raw_amt;

  assign base_word = tieoff ? {{(XLEN-1){1'b0}}, 1'b1} : operand_a_i;

  always_comb begin
    if (rotate) begin
      // Rotates wrap A around onto itself
      fill_word = operand_a_i;
    end else if (arithmetic) begin
      fill_word = {XLEN{operand_a_i[XLEN-1]}};
    end else begin
      fill_word = '0;
    end
  end

  ////////////////////////////////////////
  // Log-staged barrel over 2*XLEN
  ////////////////////////////////////////

  logic [SHAMT_W:0][2*XLEN-1:0] stage;

  assign stage[0] = {fill_word, base_word};

  for (genvar k = 0; k < SHAMT_W; k++) begin : gen_barrel
    localparam int unsigned STEP = 1 << k;
    assign stage[k+1] = shift_amt[k] ?
                        {stage[k][2*XLEN-1-STEP:0], stage[k][2*XLEN-1 -: STEP]} :
                        stage[k];
  end

  // Low half holds the shifted or rotated word
  assign shift_result_o = stage[SHAMT_W][XLEN-1:0];

  // Single-bit ops on A with the shifted word
  always_comb begin
    case (operator_i)
      ALU_BSET: bit_result_o = operand_a_i | shift_result_o;
      ALU_BCLR: bit_result_o = operand_a_i & ~shift_result_o;
      ALU_BINV: bit_result_o = operand_a_i ^ shift_result_o;
      // A was shifted right, bit zero is the one asked for
      ALU_BEXT: bit_result_o = {{(XLEN-1){1'b0}}, shift_result_o[0]};
      default:  bit_result_o = '0;
    endcase
  end

endmodule

//--- hw/alu_top.sv
`timescale 1ns/100ps

module alu_top import alu_op_pkg::*, alu_data_pkg::*; #(
  parameter int unsigned XLEN = XLEN_DEFAULT
) (
  input  alu_op_e         operator_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  output logic [XLEN-1:0] result_o,
  output logic            comparison_result_o
);

  logic [XLEN-1:0] shift_result;
  logic [XLEN-1:0] bit_result;
  logic [XLEN-1:0] add_result;
  logic [XLEN-1:0] shadd_result;
  logic [XLEN-1:0] minmax_result;
  logic            cmp_result;

  // Both units see the same inputs in parallel
  alu_shift_unit #(
    .XLEN (XLEN)
  ) i_shift_unit (
    .operator_i     (operator_i),
    .operand_a_i    (operand_a_i),
    .operand_b_i    (operand_b_i),
    .shift_result_o (shift_result),
    .bit_result_o   (bit_result)
  );

  alu_arith_unit #(
    .XLEN (XLEN)
  ) i_arith_unit (
    .operator_i      (operator_i),
    .operand_a_i     (operand_a_i),
    .operand_b_i     (operand_b_i),
    .add_result_o    (add_result),
    .shadd_result_o  (shadd_result),
    .minmax_result_o (minmax_result),
    .cmp_result_o    (cmp_result)
  );

  alu_result_mux #(
    .XLEN (XLEN)
  ) i_result_mux (
    .operator_i          (operator_i),
    .operand_a_i         (operand_a_i),
    .operand_b_i         (operand_b_i),
    .shift_result_i      (shift_result),
    .bit_result_i        (bit_result),
    .add_result_i        (add_result),
    .shadd_result_i      (shadd_result),
    .minmax_result_i     (minmax_result),
    .cmp_result_i        (cmp_result),
    .result_o            (result_o),
    .comparison_result_o (comparison_result_o)
  );

endmodule

//--- list.f
hw/alu_op_pkg.sv
hw/alu_data_pkg.sv
hw/alu_shift_unit.sv
hw/alu_arith_unit.sv
hw/alu_result_mux.sv
hw/alu_top.sv
tb/alu_properties.sv
tb/alu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module alu_tb \
  -Mdir "$BUILD_DIR" -o alu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/alu_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Pass only when the log holds the pass line
if grep -q "^TEST PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1

//--- tb/alu_properties.sv
`timescale 1ns/100ps

module alu_properties import alu_op_pkg::*, alu_data_pkg::*; #(
  parameter int unsigned XLEN = XLEN_DEFAULT
) (
  input logic            clk_i,
  input alu_op_e         operator_i,
  input logic [XLEN-1:0] operand_a_i,
  input logic [XLEN-1:0] operand_b_i,
  input logic [XLEN-1:0] result_i,
  input logic            comparison_result_i
);

  // True when the code names a listed operator
  function automatic logic code_is_kept(logic [ALU_OP_W-1:0] code);
    alu_op_e op;
    logic    found;
    found = 1'b0;
    op    = op.first();
    for (int i = 0; i < op.num(); i++) begin
      if (op == code) found = 1'b1;
      op = op.next();
    end
    return found;
  endfunction

  // Set-less-than widens the branch bit
  slt_bit_a: assert property (@(negedge clk_i)
    (operator_i inside {ALU_SLTS, ALU_SLTU}) |->
    (result_i == {{(XLEN-1){1'b0}}, comparison_result_i}))
    else $error("set-less-than result differs from the compare output");

  unused_zero_a: assert property (@(negedge clk_i)
    !code_is_kept(operator_i) |-> (result_i == '0))
    else $error("unlisted operator code gave a nonzero result");

  // Min and max only ever pass an operand through
  minmax_operand_a: assert property (@(negedge clk_i)
    (operator_i inside {ALU_MIN, ALU_MAX, ALU_MINU, ALU_MAXU}) |->
    ((result_i == operand_a_i) || (result_i == operand_b_i)))
    else $error("min or max result matches neither operand");

endmodule

//--- tb/alu_tb.sv
`timescale 1ns/100ps

module alu_tb
  import alu_op_pkg::*, alu_data_pkg::*;
();

  localparam int unsigned XLEN         = XLEN_DEFAULT;
  localparam int unsigned RESET_CYCLES = 10;
  localparam int unsigned RAND_PER_OP  = 400;

  // Directed operand pairs, applied to every operator
  // Overflow, all ones, zero, signed extremes, shift amounts 0, 31 and 37
  localparam logic [XLEN-1:0] DIR_A [10] = '{
    32'h7FFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000, 32'h8000_0000, 32'h7FFF_FFFF,
    32'h8000_0001, 32'h8000_0001, 32'hA5A5_A5A5, 32'hF0F0_F0F0, 32'h1234_5678
  };
  localparam logic [XLEN-1:0] DIR_B [10] = '{
    32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_0000, 32'h7FFF_FFFF, 32'h8000_0000,
    32'h0000_0000, 32'h0000_001F, 32'h0000_0025, 32'hFF00_FF00, 32'h1234_5678
  };
  // Codes outside the operator list
  localparam logic [ALU_OP_W-1:0] UNUSED_CODES [3] = '{6'b000100, 6'b010100, 6'b111111};

  logic            clk;
  logic            rst_n_i;
  alu_op_e         operator;
  logic [XLEN-1:0] operand_a;
  logic [XLEN-1:0] operand_b;
  logic [XLEN-1:0] result;
  logic            comparison_result;

  // Vector currently on the DUT inputs
  logic  cur_valid;
  string cur_name;

  alu_op_e         vec_op [$];
  logic [XLEN-1:0] vec_a [$];
  logic [XLEN-1:0] vec_b [$];
  string           vec_name [$];

  int            seed        = 95;
  int unsigned   cycle_count = 0;
  int unsigned   cycle_limit = 0;
  int            num_checked = 0;
  logic [XLEN:0] ref_value;

  alu_top #(
    .XLEN (XLEN)
  ) i_dut (
    .operator_i          (operator),
    .operand_a_i         (operand_a),
    .operand_b_i         (operand_b),
    .result_o            (result),
    .comparison_result_o (comparison_result)
  );

  bind alu_top alu_properties #(
    .XLEN (XLEN)
  ) i_properties (
    .clk_i               (alu_tb.clk),
    .operator_i          (operator_i),
    .operand_a_i         (operand_a_i),
    .operand_b_i         (operand_b_i),
    .result_i            (result_o),
    .comparison_result_i (comparison_result_o)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Compare bit on top, result word below
  function automatic logic [XLEN:0] alu_ref(alu_op_e op, logic [XLEN-1:0] a,
                                            logic [XLEN-1:0] b);
    logic [XLEN-1:0] res;
    logic [XLEN-1:0] one_hot;
    logic            cmp;
    int unsigned     sh;
    res     = '0;
    cmp     = 1'b0;
    // Shift amount and bit index wrap at XLEN
    sh      = b % XLEN;
    one_hot = {{(XLEN-1){1'b0}}, 1'b1} << sh;
    case (op)
      ALU_ADD:    res = a + b;
      ALU_SUB:    res = a - b;
      ALU_SH1ADD: res = (a << 1) + b;
      ALU_SH2ADD: res = (a << 2) + b;
      ALU_SH3ADD: res = (a << 3) + b;
      ALU_AND:    res = a & b;
      ALU_OR:     res = a | b;
      ALU_XOR:    res = a ^ b;
      ALU_ANDN:   res = a & ~b;
      ALU_ORN:    res = a | ~b;
      ALU_XNOR:   res = ~(a ^ b);
      ALU_SLL:    res = a << sh;
      ALU_SRL:    res = a >> sh;
      ALU_SRA:    res = $signed(a) >>> sh;
      // A shift by XLEN gives zero, so amount zero still works
      ALU_ROL:    res = (a << sh) | (a >> (XLEN - sh));
      ALU_ROR:    res = (a >> sh) | (a << (XLEN - sh));
      ALU_BSET:   res = a | one_hot;
      ALU_BCLR:   res = a & ~one_hot;
      ALU_BINV:   res = a ^ one_hot;
      ALU_BEXT:   res = (a >> sh) & {{(XLEN-1){1'b0}}, 1'b1};
      ALU_EQ:     cmp = (a == b);
      ALU_NE:     cmp = (a != b);
      ALU_GES:    cmp = ($signed(a) >= $signed(b));
      ALU_GEU:    cmp = (a >= b);
      ALU_LTS:    cmp = ($signed(a) < $signed(b));
      ALU_LTU:    cmp = (a < b);
      ALU_SLTS: begin
        cmp = ($signed(a) < $signed(b));
        res = {{(XLEN-1){1'b0}}, cmp};
      end
      ALU_SLTU: begin
        cmp = (a < b);
        res = {{(XLEN-1){1'b0}}, cmp};
      end
      // Ties pick B
      ALU_MIN:    res = ($signed(a) < $signed(b)) ? a : b;
      ALU_MAX:    res = ($signed(a) > $signed(b)) ? a : b;
      ALU_MINU:   res = (a < b) ? a : b;
      ALU_MAXU:   res = (a > b) ? a : b;
      default:    res = '0;
    endcase
    return {cmp, res};
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_word(string name, logic [XLEN-1:0] expected, logic [XLEN-1:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s result: expected %h, actual %h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "result word mismatch");
    end
  endtask

  task automatic check_cmp(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("[FAIL] %s compare: expected %b, actual %b", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "compare bit mismatch");
    end
  endtask

  ////////////////////////////////////////
  // Vector lists
  ////////////////////////////////////////

  function automatic string op_label(alu_op_e op);
    return (op.name() == "") ? "unused code" : op.name();
  endfunction

  task automatic add_vec(string kind, alu_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    vec_op.push_back(op);
    vec_a.push_back(a);
    vec_b.push_back(b);
    vec_name.push_back($sformatf("%s %s", kind, op_label(op)));
  endtask

  task automatic build_vectors();
    alu_op_e         op;
    logic [XLEN-1:0] ra;
    logic [XLEN-1:0] rb;
    // Directed pairs on every operator
    op = op.first();
    for (int i = 0; i < op.num(); i++) begin
      foreach (DIR_A[k]) add_vec("directed", op, DIR_A[k], DIR_B[k]);
      op = op.next();
    end
    foreach (UNUSED_CODES[k]) begin
      add_vec("directed", alu_op_e'(UNUSED_CODES[k]), DIR_A[k], DIR_B[k]);
    end
    // Random operands, equal pairs now and then
    op = op.first();
    for (int i = 0; i < op.num(); i++) begin
      for (int n = 0; n < RAND_PER_OP; n++) begin
        ra = $random(seed);
        rb = $random(seed);
        if (($random(seed) & 7) == 0) rb = ra;
        add_vec("random", op, ra, rb);
      end
      op = op.next();
    end
  endtask

  ////////////////////////////////////////
  // Stimulus, checker and timeout
  ////////////////////////////////////////

  initial begin
    operator  = ALU_ADD;
    operand_a = '0;
    operand_b = '0;
    cur_valid = 1'b0;
    cur_name  = "";
    rst_n_i   = 1'b0;
    build_vectors();
    cycle_limit = 2 * vec_op.size() + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n_i <= 1'b1;
    wait (rst_n_i);
    @(posedge clk);
    foreach (vec_op[i]) begin
      operator  <= vec_op[i];
      operand_a <= vec_a[i];
      operand_b <= vec_b[i];
      cur_name  <= vec_name[i];
      cur_valid <= 1'b1;
      @(posedge clk);
    end
    cur_valid <= 1'b0;
    @(negedge clk);
    if (num_checked == vec_op.size()) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("Only %0d of %0d vectors were checked", num_checked, vec_op.size());
      $display("TEST FAILED");
      $fatal(1, "incomplete run");
    end
  end

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (cur_valid) begin
      ref_value = alu_ref(operator, operand_a, operand_b);
      check_word(cur_name, ref_value[XLEN-1:0], result);
      check_cmp(cur_name, ref_value[XLEN], comparison_result);
      num_checked++;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("Simulation timed out after %0d cycles", cycle_count);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

endmodule
